// File: build.f
+incdir+verification
hw/dccm_pkg.sv
hw/lsu_stage_pipe.sv
hw/dccm_port_arb.sv
hw/ld_data_align.sv
hw/ecc_fix_ctl.sv
hw/dccm_ctl_top.sv
verification/tb_dccm_ctl.sv

// File: hw/dccm_ctl_top.sv
////////////////////////////////////////
// dccm_ctl_top
// DCCM port controller of the load/store
// unit, pipe d to m to r
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dccm_ctl_top (
   input  wire                          clk,
   input  wire                          rst,
   input  wire dccm_pkg::lsu_pkt_t      lsu_pkt_d,
   input  wire dccm_pkg::dccm_addr_t    lsu_addr_d,
   input  wire                          lsu_commit_r,
   input  wire                          stbuf_reqvld_any,
   input  wire dccm_pkg::dccm_addr_t    stbuf_addr_any,
   input  wire dccm_pkg::dccm_fdata_t   stbuf_data_any,
   input  wire dccm_pkg::dccm_dword_u   stbuf_fwd_data_m,
   input  wire [2*dccm_pkg::DCCM_BYTE_WIDTH-1:0] stbuf_fwd_byteen_m,
   input  wire                          dma_dccm_wen,
   input  wire dccm_pkg::dccm_fdata_t   dma_wdata_lo,
   input  wire dccm_pkg::dccm_fdata_t   dma_wdata_hi,
   input  wire dccm_pkg::dccm_fdata_t   dccm_rd_data_lo,   // valid in m
   input  wire dccm_pkg::dccm_fdata_t   dccm_rd_data_hi,
   input  wire                          single_ecc_error_lo_r,
   input  wire                          single_ecc_error_hi_r,
   input  wire                          double_ecc_error_r,
   input  wire dccm_pkg::dccm_fdata_t   sec_data_lo_r,
   input  wire dccm_pkg::dccm_fdata_t   sec_data_hi_r,
   output logic                         dccm_rden,
   output dccm_pkg::dccm_addr_t         dccm_rd_addr_lo,
   output dccm_pkg::dccm_addr_t         dccm_rd_addr_hi,
   output dccm_pkg::dccm_wr_t           dccm_wr,
   output logic                         lsu_stbuf_commit_any,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] lsu_ld_data_r,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] lsu_ld_data_corr_r,
   output logic                         ld_single_ecc_error_r
);
   import dccm_pkg::*;

   lsu_pkt_t   pkt_d, pkt_m, pkt_r;
   dccm_addr_t addr_d, addr_m, addr_r;
   dccm_addr_t end_d, end_m, end_r;
   logic       rden_d;
   logic       dual_r;
   logic       fix_pending;
   dccm_wr_t   fix_wr;

   lsu_stage_pipe i_lsu_stage_pipe (
      .clk, .rst, .lsu_pkt_d, .lsu_addr_d,
      .pkt_d, .pkt_m, .pkt_r,
      .addr_d, .addr_m, .addr_r,
      .end_d, .end_m, .end_r,
      .rden_d, .dual_r
   );

   dccm_port_arb i_dccm_port_arb (
      .pkt_d, .addr_d, .end_d, .rden_d,
      .stbuf_reqvld_any, .stbuf_addr_any, .stbuf_data_any,
      .dma_dccm_wen, .dma_wdata_lo, .dma_wdata_hi,
      .fix_pending, .fix_wr,
      .dccm_rden, .dccm_rd_addr_lo, .dccm_rd_addr_hi,
      .dccm_wr, .lsu_stbuf_commit_any
   );

   ld_data_align i_ld_data_align (
      .clk, .rst, .pkt_m, .dual_r, .addr_r,
      .dccm_rd_data_lo, .dccm_rd_data_hi,
      .stbuf_fwd_data_m, .stbuf_fwd_byteen_m,
      .sec_data_lo_r, .sec_data_hi_r,
      .lsu_ld_data_r, .lsu_ld_data_corr_r
   );

   ecc_fix_ctl i_ecc_fix_ctl (
      .clk, .rst, .pkt_d, .pkt_m, .pkt_r,
      .addr_d, .end_d, .addr_m, .end_m, .addr_r, .end_r,
      .lsu_commit_r, .single_ecc_error_lo_r, .single_ecc_error_hi_r,
      .double_ecc_error_r, .sec_data_lo_r, .sec_data_hi_r,
      .ld_single_ecc_error_r, .fix_pending, .fix_wr
   );

endmodule

`default_nettype wire

// File: hw/dccm_pkg.sv
////////////////////////////////////////
// dccm_pkg
// widths and shared types of the DCCM
// port controller: load/store packet,
// bank words, the write port and the
// two views of a double word
////////////////////////////////////////
`default_nettype none

package dccm_pkg;

   localparam int DCCM_BITS       = 16;  // byte address width
   localparam int DCCM_DATA_WIDTH = 32;  // data bits per bank
   localparam int DCCM_ECC_WIDTH  = 7;   // ecc bits per bank
   localparam int DCCM_BYTE_WIDTH = 4;   // bytes per bank word
   localparam int DCCM_WIDTH_BITS = 2;   // byte offset within a bank word
   localparam int DCCM_BANK_BITS  = 1;   // bank select sits at addr bit 2

   typedef logic [DCCM_BITS-1:0] dccm_addr_t;

   // one load/store op, only one of by/half/word is set
   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic dma;
      logic by;
      logic half;
      logic word;
   } lsu_pkt_t;

   // full bank word as stored in the array
   typedef struct packed {
      logic [DCCM_ECC_WIDTH-1:0]  ecc;
      logic [DCCM_DATA_WIDTH-1:0] data;
   } dccm_fdata_t;

   typedef struct packed {
      logic        en;
      dccm_addr_t  addr_lo;
      dccm_addr_t  addr_hi;
      dccm_fdata_t data_lo;
      dccm_fdata_t data_hi;
   } dccm_wr_t;

   typedef struct packed {
      logic [DCCM_DATA_WIDTH-1:0] hi;
      logic [DCCM_DATA_WIDTH-1:0] lo;
   } dccm_banks_t;

   // byte view for the forward merge, bank view for assembly and shift
   typedef union packed {
      dccm_banks_t                         banks;
      logic [2*DCCM_BYTE_WIDTH-1:0][7:0]   bytes;
   } dccm_dword_u;

endpackage

`default_nettype wire

// File: hw/dccm_port_arb.sv
////////////////////////////////////////
// dccm_port_arb
// drives the DCCM read and write ports;
// write priority is ecc fix, then DMA,
// then the store buffer drain
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module dccm_port_arb (
   input  wire dccm_pkg::lsu_pkt_t    pkt_d,
   input  wire dccm_pkg::dccm_addr_t  addr_d,
   input  wire dccm_pkg::dccm_addr_t  end_d,
   input  wire                        rden_d,
   input  wire                        stbuf_reqvld_any,
   input  wire dccm_pkg::dccm_addr_t  stbuf_addr_any,
   input  wire dccm_pkg::dccm_fdata_t stbuf_data_any,
   input  wire                        dma_dccm_wen,
   input  wire dccm_pkg::dccm_fdata_t dma_wdata_lo,
   input  wire dccm_pkg::dccm_fdata_t dma_wdata_hi,
   input  wire                        fix_pending,
   input  wire dccm_pkg::dccm_wr_t    fix_wr,
   output logic                       dccm_rden,
   output dccm_pkg::dccm_addr_t       dccm_rd_addr_lo,
   output dccm_pkg::dccm_addr_t       dccm_rd_addr_hi,
   output dccm_pkg::dccm_wr_t         dccm_wr,
   output logic                       lsu_stbuf_commit_any
);
   import dccm_pkg::*;

   logic [DCCM_BANK_BITS-1:0] sb_bank;
   logic [DCCM_BANK_BITS-1:0] rd_bank_lo;
   logic [DCCM_BANK_BITS-1:0] rd_bank_hi;
   logic                      bank_clash;
   logic                      wr_busy;

   assign dccm_rden       = rden_d;
   assign dccm_rd_addr_lo = addr_d;
   assign dccm_rd_addr_hi = end_d;   // hi bank reads the end word for dual loads

   assign sb_bank    = stbuf_addr_any[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign rd_bank_lo = addr_d[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign rd_bank_hi = end_d[DCCM_WIDTH_BITS +: DCCM_BANK_BITS];
   assign bank_clash = (sb_bank == rd_bank_lo) | (sb_bank == rd_bank_hi);

   assign wr_busy = dma_dccm_wen | fix_pending;

   // drain is allowed beside a read only when the banks differ
   assign lsu_stbuf_commit_any = stbuf_reqvld_any & ~wr_busy & (~rden_d | ~bank_clash);

   always_comb begin
      if (fix_pending) begin
         dccm_wr = fix_wr;
      end else if (dma_dccm_wen) begin
         dccm_wr.addr_lo = addr_d;
         dccm_wr.addr_hi = end_d;
         dccm_wr.data_lo = dma_wdata_lo;
         dccm_wr.data_hi = dma_wdata_hi;
      end else begin
         dccm_wr.addr_lo = stbuf_addr_any;   // same word on both banks
         dccm_wr.addr_hi = stbuf_addr_any;
         dccm_wr.data_lo = stbuf_data_any;
         dccm_wr.data_hi = stbuf_data_any;
      end
      dccm_wr.en = fix_pending | dma_dccm_wen | lsu_stbuf_commit_any;
   end

   // DMA writes take their address from the d stage, so the op must be there
   always_comb begin
      a_dma_pkt_at_d: assert (!dma_dccm_wen || (pkt_d.valid && pkt_d.dma && pkt_d.store))
         else $error("dma write without a dma store packet at d");
   end

endmodule

`default_nettype wire

// File: hw/ecc_fix_ctl.sv
////////////////////////////////////////
// ecc_fix_ctl
// qualifies single bit load errors at r
// and holds address and corrected data
// for the write back one cycle later
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ecc_fix_ctl (
   input  wire                        clk,
   input  wire                        rst,
   input  wire dccm_pkg::lsu_pkt_t    pkt_d,
   input  wire dccm_pkg::lsu_pkt_t    pkt_m,
   input  wire dccm_pkg::lsu_pkt_t    pkt_r,
   input  wire dccm_pkg::dccm_addr_t  addr_d,
   input  wire dccm_pkg::dccm_addr_t  end_d,
   input  wire dccm_pkg::dccm_addr_t  addr_m,
   input  wire dccm_pkg::dccm_addr_t  end_m,
   input  wire dccm_pkg::dccm_addr_t  addr_r,
   input  wire dccm_pkg::dccm_addr_t  end_r,
   input  wire                        lsu_commit_r,
   input  wire                        single_ecc_error_lo_r,
   input  wire                        single_ecc_error_hi_r,
   input  wire                        double_ecc_error_r,
   input  wire dccm_pkg::dccm_fdata_t sec_data_lo_r,
   input  wire dccm_pkg::dccm_fdata_t sec_data_hi_r,
   output logic                       ld_single_ecc_error_r,
   output logic                       fix_pending,
   output dccm_pkg::dccm_wr_t         fix_wr
);
   import dccm_pkg::*;

   logic        ld_err_lo, ld_err_hi;
   logic        dma_st_d, dma_st_m;
   logic        kill_lo, kill_hi;
   logic        fix_lo_ns, fix_hi_ns;
   logic        fix_lo_q, fix_hi_q;
   dccm_addr_t  sec_addr_lo_q, sec_addr_hi_q;
   dccm_fdata_t sec_lo_q, sec_hi_q;

   function automatic logic same_word(input dccm_addr_t a, input dccm_addr_t b);
      return a[DCCM_BITS-1:DCCM_WIDTH_BITS] == b[DCCM_BITS-1:DCCM_WIDTH_BITS];
   endfunction

   assign ld_err_lo = pkt_r.valid & pkt_r.load & single_ecc_error_lo_r;
   assign ld_err_hi = pkt_r.valid & pkt_r.load & single_ecc_error_hi_r;
   assign ld_single_ecc_error_r = (ld_err_lo | ld_err_hi) & ~double_ecc_error_r;

   // a younger DMA store to the failing word makes the fix stale
   assign dma_st_d = pkt_d.valid & pkt_d.store & pkt_d.dma;
   assign dma_st_m = pkt_m.valid & pkt_m.store & pkt_m.dma;
   assign kill_lo  = (dma_st_d & (same_word(addr_d, addr_r) | same_word(end_d, addr_r))) |
                     (dma_st_m & (same_word(addr_m, addr_r) | same_word(end_m, addr_r)));
   assign kill_hi  = (dma_st_d & (same_word(addr_d, end_r) | same_word(end_d, end_r))) |
                     (dma_st_m & (same_word(addr_m, end_r) | same_word(end_m, end_r)));

   assign fix_lo_ns = ld_err_lo & ~double_ecc_error_r & (lsu_commit_r | pkt_r.dma) & ~kill_lo;
   assign fix_hi_ns = ld_err_hi & ~double_ecc_error_r & (lsu_commit_r | pkt_r.dma) & ~kill_hi;

   always_ff @(posedge clk) begin
      if (rst) begin
         fix_lo_q <= 1'b0;
         fix_hi_q <= 1'b0;
      end else begin
         fix_lo_q <= fix_lo_ns;
         fix_hi_q <= fix_hi_ns;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_single_ecc_error_r) begin
         sec_addr_lo_q <= addr_r;
         sec_addr_hi_q <= end_r;
         sec_lo_q      <= sec_data_lo_r;
         sec_hi_q      <= sec_data_hi_r;
      end
   end

   assign fix_pending = fix_lo_q | fix_hi_q;

   // hi only failure puts its word on both banks
   always_comb begin
      fix_wr.en      = fix_pending;
      fix_wr.addr_lo = fix_lo_q ? sec_addr_lo_q : sec_addr_hi_q;
      fix_wr.addr_hi = fix_hi_q ? sec_addr_hi_q : sec_addr_lo_q;
      fix_wr.data_lo = fix_lo_q ? sec_lo_q : sec_hi_q;
      fix_wr.data_hi = fix_hi_q ? sec_hi_q : sec_lo_q;
   end

endmodule

`default_nettype wire

// File: hw/ld_data_align.sv
////////////////////////////////////////
// ld_data_align
// captures bank and forward data into r,
// merges forwarded store buffer bytes
// over DCCM bytes and right justifies
// the raw and corrected load data
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ld_data_align (
   input  wire                           clk,
   input  wire                           rst,
   input  wire dccm_pkg::lsu_pkt_t       pkt_m,
   input  wire                           dual_r,
   input  wire dccm_pkg::dccm_addr_t     addr_r,
   input  wire dccm_pkg::dccm_fdata_t    dccm_rd_data_lo,
   input  wire dccm_pkg::dccm_fdata_t    dccm_rd_data_hi,
   input  wire dccm_pkg::dccm_dword_u    stbuf_fwd_data_m,
   input  wire [2*dccm_pkg::DCCM_BYTE_WIDTH-1:0] stbuf_fwd_byteen_m,
   input  wire dccm_pkg::dccm_fdata_t    sec_data_lo_r,
   input  wire dccm_pkg::dccm_fdata_t    sec_data_hi_r,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] lsu_ld_data_r,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] lsu_ld_data_corr_r
);
   import dccm_pkg::*;

   localparam int DW_BYTES = 2*DCCM_BYTE_WIDTH;

   logic                       ld_m;
   logic [DCCM_DATA_WIDTH-1:0] rd_lo_r;
   logic [DCCM_DATA_WIDTH-1:0] rd_hi_r;
   dccm_dword_u                fwd_data_r;
   logic [DW_BYTES-1:0]        fwd_byteen_r;
   dccm_dword_u                mem_raw;
   dccm_dword_u                mem_corr;
   dccm_dword_u                merged_raw;
   dccm_dword_u                merged_corr;
   logic [4:0]                 shamt;

   // forwarded bytes win over the array bytes
   function automatic dccm_dword_u merge_fwd(input dccm_dword_u mem,
                                             input dccm_dword_u fwd,
                                             input logic [DW_BYTES-1:0] byteen);
      dccm_dword_u res;
      for (int i = 0; i < DW_BYTES; i++) begin
         res.bytes[i] = byteen[i] ? fwd.bytes[i] : mem.bytes[i];
      end
      return res;
   endfunction

   assign ld_m = pkt_m.valid & pkt_m.load;

   always_ff @(posedge clk) begin
      if (rst) begin
         fwd_byteen_r <= '0;
      end else if (ld_m) begin
         fwd_byteen_r <= stbuf_fwd_byteen_m;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_m) begin
         rd_lo_r    <= dccm_rd_data_lo.data;
         rd_hi_r    <= dccm_rd_data_hi.data;
         fwd_data_r <= stbuf_fwd_data_m;
      end
   end

   // the hi bank only holds load bytes when the access crosses a word
   always_comb begin
      mem_raw.banks.lo  = rd_lo_r;
      mem_raw.banks.hi  = rd_hi_r & {DCCM_DATA_WIDTH{dual_r}};
      mem_corr.banks.lo = sec_data_lo_r.data;
      mem_corr.banks.hi = sec_data_hi_r.data & {DCCM_DATA_WIDTH{dual_r}};
   end

   assign merged_raw  = merge_fwd(mem_raw, fwd_data_r, fwd_byteen_r);
   assign merged_corr = merge_fwd(mem_corr, fwd_data_r, fwd_byteen_r);

   assign shamt = {addr_r[DCCM_WIDTH_BITS-1:0], 3'b000};   // byte offset times 8

   assign lsu_ld_data_r      = DCCM_DATA_WIDTH'(merged_raw.banks >> shamt);
   assign lsu_ld_data_corr_r = DCCM_DATA_WIDTH'(merged_corr.banks >> shamt);

endmodule

`default_nettype wire

// File: hw/lsu_stage_pipe.sv
////////////////////////////////////////
// lsu_stage_pipe
// d stage decode of end address, dual
// and read need; carries packet and
// addresses through m and r
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module lsu_stage_pipe (
   input  wire                     clk,
   input  wire                     rst,
   input  wire dccm_pkg::lsu_pkt_t lsu_pkt_d,
   input  wire dccm_pkg::dccm_addr_t lsu_addr_d,
   output dccm_pkg::lsu_pkt_t      pkt_d,
   output dccm_pkg::lsu_pkt_t      pkt_m,
   output dccm_pkg::lsu_pkt_t      pkt_r,
   output dccm_pkg::dccm_addr_t    addr_d,
   output dccm_pkg::dccm_addr_t    addr_m,
   output dccm_pkg::dccm_addr_t    addr_r,
   output dccm_pkg::dccm_addr_t    end_d,
   output dccm_pkg::dccm_addr_t    end_m,
   output dccm_pkg::dccm_addr_t    end_r,
   output logic                    rden_d,
   output logic                    dual_r
);
   import dccm_pkg::*;

   logic [1:0] size_m1;   // access size minus one
   logic       dual_d;
   logic       dual_m;

   assign pkt_d  = lsu_pkt_d;
   assign addr_d = lsu_addr_d;

   assign size_m1 = lsu_pkt_d.word ? 2'd3 : (lsu_pkt_d.half ? 2'd1 : 2'd0);
   assign end_d   = lsu_addr_d + dccm_addr_t'(size_m1);
   assign dual_d  = end_d[DCCM_BITS-1:DCCM_WIDTH_BITS] !=
                    lsu_addr_d[DCCM_BITS-1:DCCM_WIDTH_BITS];

   // aligned word stores overwrite the whole word and the ecc, no read needed
   assign rden_d = lsu_pkt_d.valid &
                   (lsu_pkt_d.load |
                    (lsu_pkt_d.store & (~lsu_pkt_d.word |
                                        (lsu_addr_d[DCCM_WIDTH_BITS-1:0] != '0))));

   always_ff @(posedge clk) begin
      if (rst) begin
         pkt_m <= '0;
         pkt_r <= '0;
      end else begin
         pkt_m <= lsu_pkt_d;
         pkt_r <= pkt_m;
      end
   end

   always_ff @(posedge clk) begin
      addr_m <= lsu_addr_d;
      end_m  <= end_d;
      dual_m <= dual_d;
      addr_r <= addr_m;
      end_r  <= end_m;
      dual_r <= dual_m;
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the DCCM controller testbench with Verilator
# fails on a tool error or when the log reports a failing check

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f build.f --top-module tb_dccm_ctl --Mdir obj_dir -o Vtb_dccm_ctl
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_dccm_ctl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
   echo "simulation reported failures, see $LOG"
   exit 1
fi

echo "simulation passed"
exit 0

// File: verification/tb_dccm_vectors.svh
////////////////////////////////////////
// DCCM controller test vectors
// one row per op, each row is applied
// over four cycles d, m, r and fix
////////////////////////////////////////
`ifndef TB_DCCM_VECTORS_SVH
`define TB_DCCM_VECTORS_SVH

localparam int NUM_ROWS = 17;

// pkt, addr, rnd, bank {hi,lo}, fwd_en, err_lo, err_hi, err_dbl, commit, dma_kill,
//    sb_req, sb_addr, dma_wen, exp_commit, exp_fix
vec_t vec [NUM_ROWS] = '{
   '{IDLE,   16'h0000, 1'b0, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0100, 1'b0, 64'h8877_6655_4433_2211, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0102, 1'b1, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_H,   16'h0101, 1'b1, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_B,   16'h0203, 1'b1, 64'h0, 8'h08, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0101, 1'b1, 64'h0, 8'h30, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{IDLE,   16'h0000, 1'b0, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
     1'b1, 16'h0040, 1'b0, 1'b1, 1'b0},
   '{DMA_ST, 16'h0080, 1'b0, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
     1'b1, 16'h0044, 1'b1, 1'b0, 1'b0},
   '{LD_W,   16'h0100, 1'b1, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b1, 16'h0048, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0100, 1'b1, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b1, 16'h004c, 1'b0, 1'b1, 1'b0},
   '{ST_B,   16'h0010, 1'b0, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{ST_W,   16'h0010, 1'b0, 64'h0, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0200, 1'b1, 64'h0, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b1},
   '{LD_W,   16'h0206, 1'b1, 64'h0, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b1},
   '{LD_W,   16'h0200, 1'b1, 64'h0, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0200, 1'b1, 64'h0, 8'h00, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0},
   '{LD_W,   16'h0200, 1'b1, 64'h0, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1,
     1'b0, 16'h0000, 1'b0, 1'b0, 1'b0}
};

`endif

// File: verification/tb_dccm_ctl.sv
////////////////////////////////////////
// tb_dccm_ctl
// testbench for the DCCM port controller
// runs table rows through d, m and r and
// checks ports, load data and ecc fixes
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_dccm_ctl;
   import dccm_pkg::*;

   typedef struct packed {
      lsu_pkt_t    pkt;
      dccm_addr_t  addr;
      logic        rnd;        // bank data drawn from the lfsr
      logic [63:0] bank;       // {hi, lo} returned in m
      logic [7:0]  fwd_en;
      logic        err_lo;
      logic        err_hi;
      logic        err_dbl;
      logic        commit;
      logic        dma_kill;   // dma store to the load word at d while the load is in r
      logic        sb_req;
      dccm_addr_t  sb_addr;
      logic        dma_wen;
      logic        exp_commit;
      logic        exp_fix;
   } vec_t;

   localparam lsu_pkt_t IDLE   = 7'b0000000;
   localparam lsu_pkt_t LD_W   = 7'b1100001;
   localparam lsu_pkt_t LD_H   = 7'b1100010;
   localparam lsu_pkt_t LD_B   = 7'b1100100;
   localparam lsu_pkt_t ST_W   = 7'b1010001;
   localparam lsu_pkt_t ST_B   = 7'b1010100;
   localparam lsu_pkt_t DMA_ST = 7'b1011001;

   `include "tb_dccm_vectors.svh"

   logic        clk = 1'b0;
   logic        rst;
   lsu_pkt_t    lsu_pkt_d;
   dccm_addr_t  lsu_addr_d;
   logic        lsu_commit_r;
   logic        stbuf_reqvld_any;
   dccm_addr_t  stbuf_addr_any;
   dccm_fdata_t stbuf_data_any;
   dccm_dword_u stbuf_fwd_data_m;
   logic [7:0]  stbuf_fwd_byteen_m;
   logic        dma_dccm_wen;
   dccm_fdata_t dma_wdata_lo;
   dccm_fdata_t dma_wdata_hi;
   dccm_fdata_t dccm_rd_data_lo;
   dccm_fdata_t dccm_rd_data_hi;
   logic        single_ecc_error_lo_r;
   logic        single_ecc_error_hi_r;
   logic        double_ecc_error_r;
   dccm_fdata_t sec_data_lo_r;
   dccm_fdata_t sec_data_hi_r;
   logic        dccm_rden;
   dccm_addr_t  dccm_rd_addr_lo;
   dccm_addr_t  dccm_rd_addr_hi;
   dccm_wr_t    dccm_wr;
   logic        lsu_stbuf_commit_any;
   logic [31:0] lsu_ld_data_r;
   logic [31:0] lsu_ld_data_corr_r;
   logic        ld_single_ecc_error_r;
   logic [31:0] lfsr = 32'd91878;
   int          checks = 0;
   int          errors = 0;
   int          row;

   dccm_ctl_top i_dccm_ctl_top (.*);

   always #4 clk = ~clk;   // 8 ns period

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
      end
      return s >> 1;
   endfunction

   task automatic draw_bits(input int n, output logic [63:0] val);
      int i;
      val = '0;
      for (i = 0; i < n; i++) begin
         lfsr   = lfsr_next(lfsr);
         val[i] = lfsr[0];
      end
   endtask

   function automatic int access_size(input lsu_pkt_t p);
      if (p.word) begin
         return 4;
      end
      if (p.half) begin
         return 2;
      end
      return 1;
   endfunction

   // byte k of the result is byte off+k of the pair, forward first, hi bank only when dual
   function automatic logic [31:0] expect_load(input logic [63:0] mem, input logic [63:0] fwd,
                                               input logic [7:0] en, input logic [1:0] off,
                                               input logic dual);
      logic [31:0] res;
      int          j;
      int          k;
      res = '0;
      for (k = 0; k < 4; k++) begin
         j = int'(off) + k;
         if (en[j]) begin
            res[8*k +: 8] = fwd[8*j +: 8];
         end else if (j < 4 || dual) begin
            res[8*k +: 8] = mem[8*j +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp)
         else begin
            errors++;
            $display("Fail %0t: row %0d %s got %h expected %h", $time, row, what, got, exp);
         end
   endtask

   task automatic idle_inputs();
      lsu_pkt_d             = '0;
      lsu_addr_d            = '0;
      lsu_commit_r          = 1'b0;
      stbuf_reqvld_any      = 1'b0;
      stbuf_addr_any        = '0;
      stbuf_data_any        = '0;
      stbuf_fwd_data_m      = '0;
      stbuf_fwd_byteen_m    = '0;
      dma_dccm_wen          = 1'b0;
      dma_wdata_lo          = '0;
      dma_wdata_hi          = '0;
      dccm_rd_data_lo       = '0;
      dccm_rd_data_hi       = '0;
      single_ecc_error_lo_r = 1'b0;
      single_ecc_error_hi_r = 1'b0;
      double_ecc_error_r    = 1'b0;
      sec_data_lo_r         = '0;
      sec_data_hi_r         = '0;
   endtask

   task automatic apply_row(input vec_t v);
      logic [63:0] bank;
      logic [63:0] fwd;
      logic [63:0] sec;
      logic [63:0] tmp;
      dccm_fdata_t sec_lo;
      dccm_fdata_t sec_hi;
      dccm_fdata_t sb_d;
      dccm_fdata_t dma_lo;
      dccm_fdata_t dma_hi;
      dccm_addr_t  end_a;
      logic        dual;
      logic        is_ld;
      logic        rden_e;
      bank = v.bank;
      if (v.rnd) begin
         draw_bits(64, bank);
      end
      draw_bits(64, fwd);
      draw_bits(64, sec);
      draw_bits(14, tmp);
      sec_lo = {tmp[6:0], sec[31:0]};
      sec_hi = {tmp[13:7], sec[63:32]};
      draw_bits(39, tmp);
      sb_d = tmp[38:0];
      draw_bits(39, tmp);
      dma_lo = tmp[38:0];
      draw_bits(39, tmp);
      dma_hi = tmp[38:0];
      end_a  = v.addr + dccm_addr_t'(access_size(v.pkt) - 1);
      dual   = end_a[15:2] != v.addr[15:2];
      is_ld  = v.pkt.valid & v.pkt.load;
      // partial or misaligned stores need the old word first
      rden_e = v.pkt.valid & (v.pkt.load |
                              (v.pkt.store & ((access_size(v.pkt) < 4) |
                                              (v.addr[1:0] != 2'b00))));

      @(posedge clk);   // d
      #1;
      idle_inputs();
      lsu_pkt_d        = v.pkt;
      lsu_addr_d       = v.addr;
      stbuf_reqvld_any = v.sb_req;
      stbuf_addr_any   = v.sb_addr;
      stbuf_data_any   = sb_d;
      dma_dccm_wen     = v.dma_wen;
      dma_wdata_lo     = dma_lo;
      dma_wdata_hi     = dma_hi;
      #3;
      check_val("rden", 64'(dccm_rden), 64'(rden_e));
      if (rden_e) begin
         check_val("rd_addr_lo", 64'(dccm_rd_addr_lo), 64'(v.addr));
         check_val("rd_addr_hi", 64'(dccm_rd_addr_hi), 64'(end_a));
      end
      check_val("stbuf commit", 64'(lsu_stbuf_commit_any), 64'(v.exp_commit));
      check_val("wr en", 64'(dccm_wr.en), 64'(v.dma_wen | v.exp_commit));
      if (v.dma_wen) begin
         check_val("dma addr_lo", 64'(dccm_wr.addr_lo), 64'(v.addr));
         check_val("dma addr_hi", 64'(dccm_wr.addr_hi), 64'(end_a));
         check_val("dma data_lo", 64'(dccm_wr.data_lo), 64'(dma_lo));
         check_val("dma data_hi", 64'(dccm_wr.data_hi), 64'(dma_hi));
      end else if (v.exp_commit) begin
         check_val("sb addr_lo", 64'(dccm_wr.addr_lo), 64'(v.sb_addr));
         check_val("sb addr_hi", 64'(dccm_wr.addr_hi), 64'(v.sb_addr));
         check_val("sb data_lo", 64'(dccm_wr.data_lo), 64'(sb_d));
         check_val("sb data_hi", 64'(dccm_wr.data_hi), 64'(sb_d));
      end

      @(posedge clk);   // m, array data and forward bytes
      #1;
      idle_inputs();
      dccm_rd_data_lo    = {7'h00, bank[31:0]};
      dccm_rd_data_hi    = {7'h00, bank[63:32]};
      stbuf_fwd_data_m   = fwd;
      stbuf_fwd_byteen_m = v.fwd_en;

      @(posedge clk);   // r
      #1;
      idle_inputs();
      lsu_commit_r          = v.commit;
      single_ecc_error_lo_r = v.err_lo;
      single_ecc_error_hi_r = v.err_hi;
      double_ecc_error_r    = v.err_dbl;
      sec_data_lo_r         = sec_lo;
      sec_data_hi_r         = sec_hi;
      if (v.dma_kill) begin
         lsu_pkt_d  = DMA_ST;
         lsu_addr_d = v.addr;
      end
      #3;
      if (is_ld) begin
         check_val("ld data", 64'(lsu_ld_data_r),
                   64'(expect_load(bank, fwd, v.fwd_en, v.addr[1:0], dual)));
         check_val("ld data corr", 64'(lsu_ld_data_corr_r),
                   64'(expect_load(sec, fwd, v.fwd_en, v.addr[1:0], dual)));
      end
      check_val("single ecc", 64'(ld_single_ecc_error_r),
                64'(is_ld & (v.err_lo | v.err_hi) & ~v.err_dbl));

      @(posedge clk);   // correction write slot
      #1;
      idle_inputs();
      #3;
      check_val("fix wr en", 64'(dccm_wr.en), 64'(v.exp_fix));
      if (v.exp_fix) begin
         check_val("fix addr_lo", 64'(dccm_wr.addr_lo), 64'(v.err_lo ? v.addr : end_a));
         check_val("fix data_lo", 64'(dccm_wr.data_lo), 64'(v.err_lo ? sec_lo : sec_hi));
      end
   endtask

   initial begin
      rst = 1'b1;
      idle_inputs();
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      for (row = 0; row < NUM_ROWS; row++) begin
         apply_row(vec[row]);
      end
      @(posedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      repeat (NUM_ROWS*4 + 100) @(posedge clk);   // four cycles per row plus margin
      $display("watchdog expired before the last row finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
